// ==== Bender.yml ====
package:
  name: sram_fifo

sources:
  - files:
      - hw/sram_fifo_pkg.sv
      - hw/sram_bank.sv
      - hw/ingress_packer.sv
      - hw/egress_unpacker.sv
      - hw/sram_fifo_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_sram_fifo.sv

// ==== bench/tb_vectors.svh ====
// Stream FIFO beat table
// columns: tdata, tstrb in, tlast, source gap, sink stall, expected tstrb
typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] strb;
    logic                  last;
    logic [3:0]            gap;        // idle source cycles before the beat
    logic                  stall;      // sink holds the beat off a while
    logic [DATA_BYTES-1:0] exp_strb;   // low count bytes set
} vec_t;

localparam int NUM_VEC = 16;

localparam vec_t VECTORS [NUM_VEC] = '{
    '{96'h0001_0203_0405_0607_0809_0a0b, 12'hfff, 1'b0, 4'd0, 1'b0, 12'hfff}, // 3-beat packet
    '{96'hffff_ffff_ffff_ffff_ffff_ffff, 12'hfff, 1'b0, 4'd0, 1'b0, 12'hfff},
    '{96'h0000_0000_0000_0000_00de_adbe, 12'h007, 1'b1, 4'd1, 1'b0, 12'h007},
    '{96'h0000_0000_0000_0000_0000_00a5, 12'h001, 1'b1, 4'd0, 1'b1, 12'h001}, // single beats
    '{96'h0000_0000_0000_0000_0000_5a5a, 12'h003, 1'b1, 4'd2, 1'b0, 12'h003},
    '{96'haaaa_aaaa_aaaa_aaaa_aaaa_aaaa, 12'hfff, 1'b0, 4'd0, 1'b1, 12'hfff}, // 2-beat packet
    '{96'h0000_0000_0000_0000_c001_d00d, 12'h00f, 1'b1, 4'd0, 1'b0, 12'h00f},
    '{96'h0000_0000_0000_0012_3456_789a, 12'h01f, 1'b1, 4'd3, 1'b1, 12'h01f},
    '{96'h0000_0000_0000_fedc_ba98_7654, 12'h03f, 1'b0, 4'd0, 1'b0, 12'h03f}, // odd strobes
    '{96'h0000_0000_0080_0000_0000_0001, 12'h07f, 1'b0, 4'd0, 1'b1, 12'h07f},
    '{96'h0000_0000_5555_5555_5555_5555, 12'h0ff, 1'b1, 4'd0, 1'b0, 12'h0ff},
    '{96'h0000_0069_1234_5678_9abc_def0, 12'h1ff, 1'b1, 4'd1, 1'b0, 12'h1ff},
    '{96'h0000_8765_4321_0fed_cba9_8765, 12'h3ff, 1'b0, 4'd0, 1'b1, 12'h3ff},
    '{96'h00f0_0f0f_f0f0_0f0f_f0f0_0f0f, 12'h7ff, 1'b1, 4'd0, 1'b0, 12'h7ff},
    '{96'h8000_0000_0000_0000_0000_0001, 12'hfff, 1'b1, 4'd2, 1'b1, 12'hfff}, // lane edge bits
    '{96'h0000_0000_1357_9bdf_2468_ace0, 12'h0ff, 1'b1, 4'd0, 1'b0, 12'h0ff}
};

// ==== bench/tb_sram_fifo.sv ====
// Stream SRAM FIFO testbench
`timescale 1ns/1ps

module tb_sram_fifo
    import sram_fifo_pkg::*;
();

    localparam int SEED       = 46237;
    localparam int STALL_CYC  = 3;      // sink hold per flagged beat
    localparam int WAIT_MAX   = 200;    // cycles, any single wait
    localparam int DRAIN_MAX  = 2000;
    localparam int RAND_LEN   = 256;
    localparam int QUIET_CYC  = 8;      // idle window after the last beat
    localparam int SINK_TABLE = 0;      // ready unless the head beat is flagged
    localparam int SINK_RAND  = 1;
    localparam int SINK_HOLD  = 2;      // test body drives ready itself

    logic                  clk;
    logic                  memreset;
    logic [DATA_W-1:0]     s_axis_tdata;
    logic [DATA_BYTES-1:0] s_axis_tstrb;
    logic                  s_axis_tlast;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    logic [DATA_W-1:0]     m_axis_tdata;
    logic [DATA_BYTES-1:0] m_axis_tstrb;
    logic                  m_axis_tlast;
    logic                  m_axis_tvalid;
    logic                  m_axis_tready;

    `include "tb_vectors.svh"

    int exp_q [$];                      // rows accepted, oldest first
    int sink_mode;
    bit rand_ready [RAND_LEN];
    int rand_gap [2*NUM_VEC];

    sram_fifo_top UUT (
        .clk           (clk),
        .memreset      (memreset),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tstrb  (s_axis_tstrb),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tstrb  (m_axis_tstrb),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED at %0t: %s expected %h got %h",
                                $time, name, exp_v, act_v));
    endtask

    task automatic check_strb(input string name, input logic [DATA_BYTES-1:0] exp_v,
                              input logic [DATA_BYTES-1:0] act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED at %0t: %s expected %h got %h",
                                $time, name, exp_v, act_v));
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED at %0t: %s expected %b got %b",
                                $time, name, exp_v, act_v));
    endtask

    ////////////////////////////////////////////////////////////
    // source side
    ////////////////////////////////////////////////////////////
    task automatic push_expected(input int row);
        exp_q.push_back(row);
    endtask

    task automatic drive_row(input int row);
        s_axis_tdata  = VECTORS[row].data;
        s_axis_tstrb  = VECTORS[row].strb;
        s_axis_tlast  = VECTORS[row].last;
        s_axis_tvalid = 1'b1;
    endtask

    // entered and left at 1 ns after a rising edge
    task automatic send_beat(input int row, input int gap);
        int t;
        s_axis_tvalid = 1'b0;
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        drive_row(row);
        t = 0;
        @(negedge clk);
        while (!s_axis_tready)
        begin
            t++;
            if (t > WAIT_MAX)
                abort_run("a source beat was never accepted, s_axis_tready stayed low");
            @(negedge clk);
        end
        push_expected(row);             // transfers at the coming edge
        @(posedge clk);
        #1;
        s_axis_tvalid = 1'b0;
    endtask

    task automatic apply_reset();
        memreset      = 1'b1;
        s_axis_tvalid = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            @(posedge clk);
            #1;
            if (i == 2)
                memreset = 1'b0;
            @(negedge clk);
            check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
        end
        check_flag("s_axis_tready", 1'b1, s_axis_tready);   // first cycle out of reset
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0)
        begin
            t++;
            if (t > DRAIN_MAX)
                abort_run("sent beats never all came out on m_axis");
            @(posedge clk);
            #1;
        end
    endtask

    // sink stalled from reset, source always valid
    task automatic fill_and_release();
        int accepted;
        int more;
        sink_mode     = SINK_HOLD;
        m_axis_tready = 1'b0;
        apply_reset();
        accepted = 0;
        drive_row(0);
        @(negedge clk);
        while (s_axis_tready)
        begin
            push_expected(accepted % NUM_VEC);
            accepted++;
            if (accepted > DEPTH + 8)
                abort_run("s_axis_tready never fell with the sink stalled");
            @(posedge clk);
            #1;
            drive_row(accepted % NUM_VEC);
            @(negedge clk);
        end
        if (accepted != DEPTH)
            abort_run($sformatf("FAILED at %0t: beats accepted before full expected %0d got %0d",
                                $time, DEPTH, accepted));
        repeat (4)
        begin
            @(negedge clk);
            check_flag("s_axis_tready", 1'b0, s_axis_tready);
        end
        @(posedge clk);
        #1;
        m_axis_tready = 1'b1;           // one beat leaves
        @(posedge clk);
        #1;
        m_axis_tready = 1'b0;
        more = 0;
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            if (s_axis_tready)
            begin
                push_expected(accepted % NUM_VEC);
                accepted++;
                more++;
            end
            @(posedge clk);
            #1;
            drive_row(accepted % NUM_VEC);  // same row again if not taken
        end
        if (more != 1)
            abort_run($sformatf("FAILED at %0t: beats accepted after one drain expected 1 got %0d",
                                $time, more));
        sink_mode = SINK_TABLE;
        send_beat(accepted % NUM_VEC, 0);   // pending beat keeps valid up
    endtask

    ////////////////////////////////////////////////////////////
    // sink and monitor
    ////////////////////////////////////////////////////////////
    initial
    begin : monitor
        int                    hold_cnt;
        int                    cyc;
        int                    row;
        logic                  stalled;
        logic [DATA_W-1:0]     held_data;
        logic [DATA_BYTES-1:0] held_strb;
        logic                  held_last;
        hold_cnt = 0;
        cyc      = 0;
        stalled  = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            cyc++;
            if (memreset && sink_mode != SINK_HOLD)
                m_axis_tready = 1'b0;
            else if (sink_mode == SINK_TABLE)
            begin
                if (m_axis_tvalid && exp_q.size() != 0 && VECTORS[exp_q[0]].stall &&
                    hold_cnt < STALL_CYC)
                begin
                    m_axis_tready = 1'b0;
                    hold_cnt++;
                end
                else
                    m_axis_tready = 1'b1;
            end
            else if (sink_mode == SINK_RAND)
                m_axis_tready = rand_ready[cyc % RAND_LEN];
            @(negedge clk);                 // values here hold until the edge
            if (memreset)
                stalled = 1'b0;
            else
            begin
                if (stalled)                // beat must not move while held
                begin
                    check_flag("m_axis_tvalid", 1'b1, m_axis_tvalid);
                    check_data("m_axis_tdata", held_data, m_axis_tdata);
                    check_strb("m_axis_tstrb", held_strb, m_axis_tstrb);
                    check_flag("m_axis_tlast", held_last, m_axis_tlast);
                end
                stalled = m_axis_tvalid && !m_axis_tready;
                held_data = m_axis_tdata;
                held_strb = m_axis_tstrb;
                held_last = m_axis_tlast;
                if (m_axis_tvalid && m_axis_tready)
                begin
                    if (exp_q.size() == 0)
                        abort_run("m_axis sent a beat that was never accepted");
                    row = exp_q.pop_front();
                    check_data("m_axis_tdata", VECTORS[row].data, m_axis_tdata);
                    check_strb("m_axis_tstrb", VECTORS[row].exp_strb, m_axis_tstrb);
                    check_flag("m_axis_tlast", VECTORS[row].last, m_axis_tlast);
                    hold_cnt = 0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int late_beats;
        void'($urandom(SEED));
        for (int i = 0; i < RAND_LEN; i++)
            rand_ready[i] = ($urandom_range(0, 2) != 0);   // ready about 2 of 3
        for (int i = 0; i < 2*NUM_VEC; i++)
            rand_gap[i] = $urandom_range(0, 3);
        memreset      = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tstrb  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        sink_mode     = SINK_TABLE;
        apply_reset();
        for (int r = 0; r < NUM_VEC; r++)
            send_beat(r, VECTORS[r].gap);
        wait_drain();
        fill_and_release();
        wait_drain();
        sink_mode = SINK_RAND;              // random back-pressure, two passes
        for (int i = 0; i < 2*NUM_VEC; i++)
            send_beat(i % NUM_VEC, rand_gap[i]);
        wait_drain();
        // nothing may follow the last beat
        late_beats = 0;
        for (int i = 0; i < QUIET_CYC; i++)
        begin
            @(negedge clk);
            if (m_axis_tvalid)
                late_beats++;
        end
        if (late_beats != 0)
            abort_run("m_axis_tvalid came up again after every sent beat had left");
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== hw/egress_unpacker.sv ====
// Stream egress and entry unpacker
`timescale 1ns/1ps

module egress_unpacker
    import sram_fifo_pkg::*;
(
    input  logic                        clk,
    input  logic                        memreset,
    input  logic [ADDR_W:0]             wr_ptr,
    output logic [ADDR_W:0]             rd_ptr,     // release pointer
    output logic                        rd_en,
    output logic [ADDR_W-1:0]           rd_addr,
    input  logic [NUM_BANKS*LANE_W-1:0] rd_lane,
    input  logic                        rd_valid,
    output logic [DATA_W-1:0]           m_axis_tdata,
    output logic [DATA_BYTES-1:0]       m_axis_tstrb,
    output logic                        m_axis_tlast,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready
);

    logic [ADDR_W:0]    issue_ptr;                  // next slot to read
    logic [CRED_W-1:0]  inflight;                   // reads in the bank pipe
    logic [CRED_W-1:0]  buf_cnt;
    logic [CRED_W:0]    credit_used;                // one bit wider, no wrap
    logic [SLOT_W-1:0]  head;
    logic [SLOT_W-1:0]  tail;
    logic [ENTRY_W-1:0] out_buf [OUT_SLOTS];
    logic [ENTRY_W-1:0] head_entry;
    logic [CNT_W-1:0]   head_cnt;
    logic               pop;

    ////////////////////////////////////////////////////////////
    // read issue under credits
    ////////////////////////////////////////////////////////////
    // a read is only sent when its return has a free slot
    assign credit_used = inflight + buf_cnt;
    assign rd_en   = (issue_ptr != wr_ptr) &&                  // not empty
                     (credit_used < (CRED_W + 1)'(OUT_SLOTS));
    assign rd_addr = issue_ptr[ADDR_W-1:0];

    assign pop = m_axis_tvalid && m_axis_tready;

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            issue_ptr <= '0;
            rd_ptr    <= '0;
            inflight  <= '0;
            buf_cnt   <= '0;
            head      <= '0;
            tail      <= '0;
        end
        else
        begin
            if (rd_en)
            begin
                issue_ptr <= issue_ptr + 1'b1;
            end
            // slot goes back to ingress once its beat has left,
            // so banks and buffer together never hold more than DEPTH
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                head   <= head + 1'b1;
            end
            if (rd_valid)
            begin
                tail <= tail + 1'b1;
            end
            inflight <= inflight + CRED_W'(rd_en) - CRED_W'(rd_valid);
            buf_cnt  <= buf_cnt + CRED_W'(rd_valid) - CRED_W'(pop);
        end
    end

    ////////////////////////////////////////////////////////////
    // output buffer
    ////////////////////////////////////////////////////////////
    // lanes are stacked low first, the pad bits of lane 2 fall off
    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            out_buf[tail] <= rd_lane[ENTRY_W-1:0];
        end
    end

    assign head_entry = out_buf[head];
    assign head_cnt   = head_entry[DATA_W +: CNT_W];

    // master side straight from the head slot
    assign m_axis_tvalid = (buf_cnt != '0);
    assign m_axis_tdata  = head_entry[DATA_W-1:0];
    assign m_axis_tlast  = head_entry[ENTRY_W-1];

    // strobe rebuild, low head_cnt bytes set
    always_comb
    begin
        for (int i = 0; i < DATA_BYTES; i++)
        begin
            m_axis_tstrb[i] = (i < int'(head_cnt));
        end
    end

    // credits must leave room for every bank return
    a_buf_no_ovf: assert property (
        @(posedge clk) disable iff (memreset)
        rd_valid |-> (buf_cnt < CRED_W'(OUT_SLOTS))
    ) else $error("output buffer overflow");

    a_hold_stall: assert property (
        @(posedge clk) disable iff (memreset)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) &&
             $stable(m_axis_tstrb) && $stable(m_axis_tlast))
    ) else $error("m_axis changed while stalled");

endmodule

// ==== hw/ingress_packer.sv ====
// Stream ingress and entry packer
`timescale 1ns/1ps

module ingress_packer
    import sram_fifo_pkg::*;
(
    input  logic                        clk,
    input  logic                        memreset,
    input  logic [DATA_W-1:0]           s_axis_tdata,
    input  logic [DATA_BYTES-1:0]       s_axis_tstrb,
    input  logic                        s_axis_tlast,
    input  logic                        s_axis_tvalid,
    output logic                        s_axis_tready,
    input  logic [ADDR_W:0]             rd_ptr,     // release pointer from egress
    output logic [ADDR_W:0]             wr_ptr,
    output logic                        wr_en,
    output logic [ADDR_W-1:0]           wr_addr,
    output logic [NUM_BANKS*LANE_W-1:0] wr_lane
);

    logic [CNT_W-1:0]   byte_cnt;   // set strobe bits
    logic [ENTRY_W-1:0] entry_q;    // beat waiting for its write
    logic               wr_pend;
    logic [ADDR_W:0]    level;      // stored plus pending
    logic               accept;

    ////////////////////////////////////////////////////////////
    // strobe compression
    ////////////////////////////////////////////////////////////
    // strobe is a low-aligned run, so the popcount is enough
    always_comb
    begin
        byte_cnt = '0;
        for (int i = 0; i < DATA_BYTES; i++)
        begin
            byte_cnt = byte_cnt + CNT_W'(s_axis_tstrb[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // occupancy and handshake
    ////////////////////////////////////////////////////////////
    assign level = (wr_ptr - rd_ptr) + (ADDR_W + 1)'(wr_pend);
    assign s_axis_tready = (level != (ADDR_W + 1)'(DEPTH));    // full at 64
    assign accept = s_axis_tvalid && s_axis_tready;

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_pend <= 1'b0;
            wr_ptr  <= '0;
        end
        else
        begin
            if (wr_pend)
            begin
                wr_ptr <= wr_ptr + 1'b1;    // visible at the write edge
            end
            wr_pend <= accept;
        end
    end

    // payload only, qualified by wr_pend
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            entry_q <= {s_axis_tlast, byte_cnt, s_axis_tdata};
        end
    end

    // write side, one cycle after the transfer
    assign wr_en   = wr_pend;
    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign wr_lane = {{(NUM_BANKS*LANE_W - ENTRY_W){1'b0}}, entry_q};  // pad lane 2

    // a strobe with a gap or an empty one cannot be rebuilt from a count
    a_strb_contig: assert property (
        @(posedge clk) disable iff (memreset)
        s_axis_tvalid |-> (s_axis_tstrb != '0) &&
                          ((s_axis_tstrb & (s_axis_tstrb + 1'b1)) == '0)
    ) else $error("tstrb not contiguous from byte 0");

endmodule

// ==== hw/sram_bank.sv ====
// SRAM bank with pipelined read
`timescale 1ns/1ps

module sram_bank
    import sram_fifo_pkg::*;
(
    input  logic              clk,
    input  logic              memreset,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LANE_W-1:0] wr_lane,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [LANE_W-1:0] rd_lane,
    output logic              rd_valid
);

    logic [LANE_W-1:0]   mem [DEPTH];       // one lane of every entry
    logic [LANE_W-1:0]   rd_pipe [READ_LAT];
    logic [READ_LAT-1:0] vld_pipe;          // stage valids, bit 0 first

    ////////////////////////////////////////////////////////////
    // array and read data pipe
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_lane;
        end
        if (rd_en)
        begin
            rd_pipe[0] <= mem[rd_addr];     // sampled at the issue edge
        end
        for (int i = 1; i < READ_LAT; i++)
        begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // valid tracks the data stage for stage
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            vld_pipe <= '0;
        end
        else
        begin
            vld_pipe <= {vld_pipe[READ_LAT-2:0], rd_en};
        end
    end

    assign rd_lane  = rd_pipe[READ_LAT-1];
    assign rd_valid = vld_pipe[READ_LAT-1];

    // the pointer pair keeps the read slot away from the write slot
    a_no_collide: assert property (
        @(posedge clk) disable iff (memreset)
        (wr_en && rd_en) |-> (wr_addr != rd_addr)
    ) else $error("bank write and read hit the same address");

endmodule

// ==== hw/sram_fifo_pkg.sv ====
// Stream SRAM FIFO constants
package sram_fifo_pkg;

    ////////////////////////////////////////////////////////////
    // stream side
    ////////////////////////////////////////////////////////////
    localparam int DATA_BYTES = 12;                 // bytes per beat
    localparam int DATA_W     = DATA_BYTES * 8;     // tdata, 96 bits
    localparam int CNT_W      = 4;                  // holds 0..12 valid bytes

    // stored entry, low to high: data, count, last
    localparam int ENTRY_W    = DATA_W + CNT_W + 1; // 101 bits

    ////////////////////////////////////////////////////////////
    // bank layout
    ////////////////////////////////////////////////////////////
    localparam int NUM_BANKS  = 3;                  // one lane per bank
    localparam int LANE_W     = 36;                 // bank word width
    // lane 0 = entry[35:0], lane 1 = entry[71:36]
    // lane 2 = entry[100:72], top 7 bits zero
    localparam int ADDR_W     = 6;
    localparam int DEPTH      = 64;                 // entries, 2**ADDR_W

    // fixed read pipeline of every bank
    localparam int READ_LAT   = 2;

    ////////////////////////////////////////////////////////////
    // egress buffering
    ////////////////////////////////////////////////////////////
    // needs READ_LAT + 2 slots to keep one beat per cycle
    localparam int OUT_SLOTS  = 4;
    localparam int SLOT_W     = $clog2(OUT_SLOTS);      // slot index
    localparam int CRED_W     = $clog2(OUT_SLOTS + 1);  // 0..OUT_SLOTS

    // pointers carry one wrap bit above the address,
    // so full and empty tell apart at equal addresses

endpackage

// ==== hw/sram_fifo_top.sv ====
// Stream SRAM FIFO top level
`timescale 1ns/1ps

module sram_fifo_top
    import sram_fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  memreset,
    // slave stream in
    input  logic [DATA_W-1:0]     s_axis_tdata,
    input  logic [DATA_BYTES-1:0] s_axis_tstrb,
    input  logic                  s_axis_tlast,
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,
    // master stream out
    output logic [DATA_W-1:0]     m_axis_tdata,
    output logic [DATA_BYTES-1:0] m_axis_tstrb,
    output logic                  m_axis_tlast,
    output logic                  m_axis_tvalid,
    input  logic                  m_axis_tready
);

    ////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////
    logic                        wr_en;
    logic [ADDR_W-1:0]           wr_addr;
    logic [NUM_BANKS*LANE_W-1:0] wr_lane;   // all lanes, lane 0 lowest
    logic [ADDR_W:0]             wr_ptr;
    logic [ADDR_W:0]             rd_ptr;
    logic                        rd_en;
    logic [ADDR_W-1:0]           rd_addr;
    logic [NUM_BANKS*LANE_W-1:0] rd_lane;
    logic [NUM_BANKS-1:0]        bank_valid; // identical, same latency
    logic                        rd_valid;

    assign rd_valid = bank_valid[0];

    ingress_packer u_ingress (
        .clk           (clk),
        .memreset      (memreset),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tstrb  (s_axis_tstrb),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .rd_ptr        (rd_ptr),
        .wr_ptr        (wr_ptr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_lane       (wr_lane)
    );

    // one 36-bit bank per lane, shared addresses
    for (genvar i = 0; i < NUM_BANKS; i++)
    begin : bank_gen
        sram_bank u_bank (
            .clk      (clk),
            .memreset (memreset),
            .wr_en    (wr_en),
            .wr_addr  (wr_addr),
            .wr_lane  (wr_lane[i*LANE_W +: LANE_W]),
            .rd_en    (rd_en),
            .rd_addr  (rd_addr),
            .rd_lane  (rd_lane[i*LANE_W +: LANE_W]),
            .rd_valid (bank_valid[i])
        );
    end

    egress_unpacker u_egress (
        .clk           (clk),
        .memreset      (memreset),
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_lane       (rd_lane),
        .rd_valid      (rd_valid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tstrb  (m_axis_tstrb),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// ==== sim.f ====
+incdir+bench
hw/sram_fifo_pkg.sv
hw/sram_bank.sv
hw/ingress_packer.sv
hw/egress_unpacker.sv
hw/sram_fifo_top.sv
bench/tb_sram_fifo.sv
